// ==== build.f ====
+incdir+design
design/axil_regs_pkg.sv
design/axil_reg_file.sv
design/axil_write_ctrl.sv
design/axil_read_ctrl.sv
design/axil_regs_top.sv
testbench/axil_regs_tb.sv

// ==== testbench/axil_regs_tb.sv ====
`include "axil_regs_defines.svh"

module axil_regs_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int         WAIT_LIMIT  = 64;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic        clk;
    logic        rst_n;
    logic        awvalid;
    logic        awready;
    logic [31:0] awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;

    // shadow of the register bank and expected responses
    logic [31:0] shadow [`AXIL_REG_COUNT];
    logic [31:0] wr_addr_hold;
    logic [31:0] exp_rdata;
    logic [1:0]  exp_rresp;
    logic [1:0]  exp_bresp;

    int    seed;
    string cur_test;
    int    test_errors;
    int    total_errors;
    int    tests_run;

    axil_regs_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    always #50 clk = ~clk;

    // word aligned and inside 0x00..0x3C
    function automatic logic addr_valid(input logic [31:0] a);
        return (a[31:6] == '0) && (a[1:0] == 2'b00);
    endfunction

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    // one in bad_odds addresses is broken, either upper bits or offset
    function automatic logic [31:0] pick_addr(input int bad_odds);
        logic [31:0] r;
        logic [31:0] a;
        r = rand_word();
        a = {26'd0, r[3:0], 2'b00};
        if (bad_odds > 0 && (r[15:8] % bad_odds) == 0) begin
            if (r[16]) begin
                a[31:6] = r[31:6] | 26'h1;
            end else begin
                a[1:0] = (r[18:17] == 2'b00) ? 2'b01 : r[18:17];
            end
        end
        return a;
    endfunction

    // model follows the bus, data lands at the W beat, reads sample at AR
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `AXIL_REG_COUNT; i++) begin
                shadow[i] <= '0;
            end
            wr_addr_hold <= '0;
            exp_rdata    <= '0;
            exp_rresp    <= RESP_OKAY;
            exp_bresp    <= RESP_OKAY;
        end else begin
            if (awvalid && awready) begin
                wr_addr_hold <= awaddr;
            end
            if (wvalid && wready) begin
                if (addr_valid(wr_addr_hold)) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb[b]) begin
                            shadow[wr_addr_hold[5:2]][b*8 +: 8] <= wdata[b*8 +: 8];
                        end
                    end
                    exp_bresp <= RESP_OKAY;
                end else begin
                    exp_bresp <= RESP_SLVERR;
                end
            end
            if (arvalid && arready) begin
                if (addr_valid(araddr)) begin
                    exp_rdata <= shadow[araddr[5:2]];
                    exp_rresp <= RESP_OKAY;
                end else begin
                    exp_rdata <= '0;
                    exp_rresp <= RESP_SLVERR;
                end
            end
        end
    end

    task automatic log_mismatch(input string what, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
        $display("Error: %s %s expected %h actual %h", cur_test, what, exp_val, act_val);
        test_errors++;
        total_errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("Failure in %s: %s", cur_test, msg);
        test_errors++;
        total_errors++;
    endtask

    a_b_resp: assert property (
        @(posedge clk) disable iff (!rst_n)
        bvalid && bready |-> bresp == exp_bresp
    ) else log_mismatch("bresp", $sampled(exp_bresp), $sampled(bresp));

    a_r_data: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid && rready |-> rdata == exp_rdata
    ) else log_mismatch("rdata", $sampled(exp_rdata), $sampled(rdata));

    a_r_resp: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid && rready |-> rresp == exp_rresp
    ) else log_mismatch("rresp", $sampled(exp_rresp), $sampled(rresp));

    a_b_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp)
    ) else report_failure("write response changed before bready");

    a_r_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    ) else report_failure("read response changed before rready");

    task automatic finish_run();
        $display("tests run %0d, errors %0d", tests_run, total_errors);
        if (total_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    task automatic tick_timeout(inout int waited, input string what);
        waited++;
        if (waited > WAIT_LIMIT) begin
            report_failure({"timed out waiting for ", what});
            finish_run();
        end
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int b_delay);
        int waited;
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        waited = 0;
        @(negedge clk);
        while (!awready) begin
            tick_timeout(waited, "awready");
            @(negedge clk);
        end
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        waited = 0;
        @(negedge clk);
        while (!wready) begin
            tick_timeout(waited, "wready");
            @(negedge clk);
        end
        @(posedge clk);
        wvalid <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!bvalid) begin
            tick_timeout(waited, "bvalid");
            @(negedge clk);
        end
        // stall the response channel for a while
        repeat (b_delay) @(posedge clk);
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, input int r_delay);
        int waited;
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        waited = 0;
        @(negedge clk);
        while (!arready) begin
            tick_timeout(waited, "arready");
            @(negedge clk);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!rvalid) begin
            tick_timeout(waited, "rvalid");
            @(negedge clk);
        end
        repeat (r_delay) @(posedge clk);
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic end_test();
        // let the last transfer's checks settle
        @(negedge clk);
        $display("test %-14s %s, %0d errors", cur_test,
                 (test_errors == 0) ? "passed" : "failed", test_errors);
    endtask

    initial begin
        logic [31:0] r;
        clk     = 1'b0;
        rst_n   = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        seed         = 32'h3958;
        cur_test     = "reset";
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        begin_test("reset_state");
        @(negedge clk);
        assert (awready && arready && !wready && !bvalid && !rvalid)
            else report_failure("handshake outputs not in their idle state after reset");
        for (int i = 0; i < `AXIL_REG_COUNT; i++) begin
            axi_read(i * 4, 0);
        end
        end_test();

        begin_test("full_word");
        for (int i = 0; i < `AXIL_REG_COUNT; i++) begin
            axi_write(i * 4, rand_word(), 4'hF, 0);
        end
        for (int i = 0; i < `AXIL_REG_COUNT; i++) begin
            axi_read(i * 4, 0);
        end
        end_test();

        begin_test("byte_strobes");
        axi_write(32'h18, 32'hA5A5_5A5A, 4'hF, 0);
        for (int s = 1; s < 16; s++) begin
            axi_write(32'h18, rand_word(), s[3:0], 0);
            axi_read(32'h18, 0);
        end
        end_test();

        begin_test("addr_errors");
        axi_write(32'h04, 32'h1234_5678, 4'hF, 0);
        axi_write(32'h20, 32'h9ABC_DEF0, 4'hF, 0);
        // index 1 with bit 8 set, then index 8 off by two bytes
        axi_write(32'h0000_0104, 32'hFFFF_FFFF, 4'hF, 0);
        axi_write(32'h0000_0022, 32'hFFFF_FFFF, 4'hF, 0);
        axi_read(32'h0000_0104, 0);
        axi_read(32'h0000_0022, 0);
        axi_read(32'h8000_0004, 0);
        axi_read(32'h04, 0);
        axi_read(32'h20, 0);
        end_test();

        begin_test("back_pressure");
        for (int i = 0; i < 12; i++) begin
            r = rand_word();
            axi_write(pick_addr(0), rand_word(), 4'hF, r[2:0]);
            axi_read(pick_addr(0), r[6:4]);
        end
        end_test();

        begin_test("random_traffic");
        fork
            begin
                logic [31:0] wr_r;
                for (int i = 0; i < 40; i++) begin
                    wr_r = rand_word();
                    axi_write(pick_addr(6), rand_word(), wr_r[3:0], wr_r[5:4]);
                end
            end
            begin
                logic [31:0] rd_r;
                for (int i = 0; i < 40; i++) begin
                    rd_r = rand_word();
                    axi_read(pick_addr(6), rd_r[1:0]);
                end
            end
        join
        end_test();

        finish_run();
    end

endmodule

// ==== design/axil_regs_top.sv ====
`include "axil_regs_defines.svh"

module axil_regs_top
    import axil_regs_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // write address
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] awaddr,

    // write data
    input  logic        wvalid,
    output logic        wready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,

    // write response
    output logic        bvalid,
    input  logic        bready,
    output axi_resp_t   bresp,

    // read address
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,

    // read data
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output axi_resp_t   rresp
);

    logic                    reg_wr_en;
    logic [3:0]              reg_wr_index;
    logic [3:0]              reg_wr_strb;
    logic [`AXIL_DATA_W-1:0] reg_wr_data;
    logic [3:0]              reg_rd_index;
    logic [`AXIL_DATA_W-1:0] reg_rd_data;

    axil_write_ctrl u_write_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .awvalid      (awvalid),
        .awready      (awready),
        .awaddr       (awaddr),
        .wvalid       (wvalid),
        .wready       (wready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .bvalid       (bvalid),
        .bready       (bready),
        .bresp        (bresp),
        .reg_wr_en    (reg_wr_en),
        .reg_wr_index (reg_wr_index),
        .reg_wr_strb  (reg_wr_strb),
        .reg_wr_data  (reg_wr_data)
    );

    axil_read_ctrl u_read_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp),
        .reg_rd_index (reg_rd_index),
        .reg_rd_data  (reg_rd_data)
    );

    axil_reg_file u_reg_file (
        .clk          (clk),
        .rst_n        (rst_n),
        .reg_wr_en    (reg_wr_en),
        .reg_wr_index (reg_wr_index),
        .reg_wr_strb  (reg_wr_strb),
        .reg_wr_data  (reg_wr_data),
        .reg_rd_index (reg_rd_index),
        .reg_rd_data  (reg_rd_data)
    );

endmodule

// ==== design/axil_read_ctrl.sv ====
`include "axil_regs_defines.svh"

module axil_read_ctrl
    import axil_regs_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,

    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output axi_resp_t   rresp,

    output logic [3:0]  reg_rd_index,
    input  logic [31:0] reg_rd_data
);

    typedef enum logic {
        R_IDLE,
        R_RESP
    } r_state_t;

    r_state_t   state;
    r_state_t   state_nxt;
    axil_addr_u ar_view;
    axil_addr_u rd_addr;
    logic       ar_ok;
    logic       ar_fire;

    assign arready = (state == R_IDLE);
    assign rvalid  = (state == R_RESP);
    assign ar_fire = arvalid && arready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= R_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            R_IDLE: begin
                if (arvalid) begin
                    state_nxt = R_RESP;
                end
            end
            R_RESP: begin
                if (rready) begin
                    state_nxt = R_IDLE;
                end
            end
            default: state_nxt = R_IDLE;
        endcase
    end

    // decode the incoming address directly
    assign ar_view.raw = araddr;
    assign ar_ok = (ar_view.fields.upper == '0) && (ar_view.fields.offset == 2'b00);

    // storage index follows araddr while idle, else the held address
    assign reg_rd_index = (state == R_IDLE) ? ar_view.fields.index : rd_addr.fields.index;

    // data sampled at the AR beat, so later writes don't show up
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr.raw <= '0;
            rdata       <= '0;
            rresp       <= OKAY;
        end else if (ar_fire) begin
            rd_addr.raw <= araddr;
            rdata       <= ar_ok ? reg_rd_data : '0;
            rresp       <= ar_ok ? OKAY : SLVERR;
        end
    end

    // held read beat must stay put under back-pressure
    a_r_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    );

endmodule

// ==== design/axil_write_ctrl.sv ====
`include "axil_regs_defines.svh"

module axil_write_ctrl
    import axil_regs_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] awaddr,

    input  logic        wvalid,
    output logic        wready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,

    output logic        bvalid,
    input  logic        bready,
    output axi_resp_t   bresp,

    output logic        reg_wr_en,
    output logic [3:0]  reg_wr_index,
    output logic [3:0]  reg_wr_strb,
    output logic [31:0] reg_wr_data
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_DATA,
        W_RESP
    } w_state_t;

    w_state_t   state;
    w_state_t   state_nxt;
    axil_addr_u wr_addr;
    logic       addr_ok;
    logic       aw_fire;
    logic       w_fire;

    assign awready = (state == W_IDLE);
    assign wready  = (state == W_DATA);
    assign bvalid  = (state == W_RESP);

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= W_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            W_IDLE: begin
                if (awvalid) begin
                    state_nxt = W_DATA;
                end
            end
            W_DATA: begin
                if (wvalid) begin
                    state_nxt = W_RESP;
                end
            end
            W_RESP: begin
                if (bready) begin
                    state_nxt = W_IDLE;
                end
            end
            default: state_nxt = W_IDLE;
        endcase
    end

    // address held from AW until the response is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_addr.raw <= '0;
        end else if (aw_fire) begin
            wr_addr.raw <= awaddr;
        end
    end

    // only word aligned offsets 0x00..0x3C are accepted
    assign addr_ok = (wr_addr.fields.upper == '0) && (wr_addr.fields.offset == 2'b00);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bresp <= OKAY;
        end else if (w_fire) begin
            bresp <= addr_ok ? OKAY : SLVERR;
        end
    end

    // a rejected write never reaches the storage
    assign reg_wr_en    = w_fire && addr_ok;
    assign reg_wr_index = wr_addr.fields.index;
    assign reg_wr_strb  = wstrb;
    assign reg_wr_data  = wdata;

    // response must not move while the master stalls
    a_b_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp)
    );

    // every register update is a W beat and is answered on B next cycle
    a_wr_en_on_w: assert property (
        @(posedge clk) disable iff (!rst_n)
        reg_wr_en |-> (wvalid && wready) ##1 (bvalid && bresp == OKAY)
    );

endmodule

// ==== design/axil_reg_file.sv ====
`include "axil_regs_defines.svh"

module axil_reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        reg_wr_en,
    input  logic [3:0]  reg_wr_index,
    input  logic [3:0]  reg_wr_strb,
    input  logic [31:0] reg_wr_data,
    input  logic [3:0]  reg_rd_index,
    output logic [31:0] reg_rd_data
);

    localparam int BYTES = `AXIL_DATA_W / 8;

    logic [`AXIL_DATA_W-1:0] regs [`AXIL_REG_COUNT];

    // byte lanes only change where the strobe is set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `AXIL_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wr_en) begin
            for (int b = 0; b < BYTES; b++) begin
                if (reg_wr_strb[b]) begin
                    regs[reg_wr_index][b*8 +: 8] <= reg_wr_data[b*8 +: 8];
                end
            end
        end
    end

    // plain lookup, no read latency
    assign reg_rd_data = regs[reg_rd_index];

endmodule

// ==== design/axil_regs_pkg.sv ====
`include "axil_regs_defines.svh"

package axil_regs_pkg;

    // AXI response codes used by this slave
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    // word address as seen by the register block
    typedef struct packed {
        logic [`AXIL_ADDR_W-7:0] upper;
        logic [3:0]              index;
        logic [1:0]              offset;
    } axil_addr_fields_t;

    // one address word, raw or split into fields
    typedef union packed {
        logic [`AXIL_ADDR_W-1:0] raw;
        axil_addr_fields_t       fields;
    } axil_addr_u;

endpackage

// ==== design/axil_regs_defines.svh ====
`ifndef AXIL_REGS_DEFINES_SVH
`define AXIL_REGS_DEFINES_SVH

// bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// register bank depth, index is 4 bits
`define AXIL_REG_COUNT 16

`endif
